//--- Makefile
# Verilator flow for the memory-port controller

VERILATOR ?= verilator
FILELIST ?= build.f
TOP ?= tb_mpc
RTL_TOP ?= mpc_top
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
RTL_SRCS ?= hw/mpc_pkg.sv hw/mpc_apb_regs.sv hw/mpc_fsm.sv hw/mpc_strip_cnt.sv \
	hw/mpc_strip_buf.sv hw/mpc_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
hw/mpc_pkg.sv
hw/mpc_apb_regs.sv
hw/mpc_fsm.sv
hw/mpc_strip_cnt.sv
hw/mpc_strip_buf.sv
hw/mpc_top.sv
test/tb_mem_model.sv
test/tb_mpc.sv

//--- hw/mpc_apb_regs.sv
`timescale 1ns/1ns

module mpc_apb_regs (
	input  logic clk,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  mpc_pkg::apb_addr_t paddr,
	input  mpc_pkg::data_t pwdata,
	output mpc_pkg::data_t prdata,
	output logic pready,
	output logic pslverr,
	input  logic busy,
	output logic start,
	output mpc_pkg::xfer_cmd_t xfer_cmd,
	output logic buf_we,
	output mpc_pkg::strip_t buf_addr,
	output mpc_pkg::data_t buf_wdata,
	input  mpc_pkg::data_t buf_rdata
);

	logic access;
	logic wr_acc;
	logic rd_acc;
	logic is_ctrl;
	logic is_addr;
	logic is_status;
	logic in_buf;
	logic unmapped;
	logic start_bit;
	logic busy_q;
	logic busy_fell;
	logic done_q;
	mpc_pkg::xfer_cmd_t cmd_q;

	// ==================================================
	// Address decode
	// ==================================================

	// No wait states, every access phase completes at once
	assign access = psel && penable;
	assign pready = access;
	assign wr_acc = access && pwrite;
	assign rd_acc = access && !pwrite;

	assign is_ctrl = (paddr == mpc_pkg::reg_ctrl);
	assign is_addr = (paddr == mpc_pkg::reg_addr);
	assign is_status = (paddr == mpc_pkg::reg_status);
	assign in_buf = (paddr >= mpc_pkg::buf_base) && (paddr <= mpc_pkg::buf_last);
	assign unmapped = !(is_ctrl || is_addr || is_status || in_buf);
	assign start_bit = pwdata[mpc_pkg::ctrl_start_bit];

	// Errors: start or buffer access during a transfer, or a hole in the map
	assign pslverr = access && (unmapped || (in_buf && busy)
		|| (is_ctrl && pwrite && start_bit && busy));
	assign start = wr_acc && is_ctrl && start_bit && !busy;

	// The buffer port reads every cycle, so the setup phase pre-fetches the word
	assign buf_addr = paddr[2 +: mpc_pkg::strip_w];
	assign buf_wdata = pwdata;
	assign buf_we = wr_acc && in_buf && !busy;

	// One cycle after busy drops the transfer counts as finished
	assign busy_fell = busy_q && !busy;
	assign xfer_cmd = cmd_q;

	// ==================================================
	// Register state
	// ==================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_q <= '0;
			busy_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			busy_q <= busy;
			// Command fields are frozen while a transfer runs
			if (wr_acc && !busy) begin
				if (is_ctrl) begin
					cmd_q.op <= mpc_pkg::mpc_op_t'(pwdata[mpc_pkg::ctrl_op_bit]);
					cmd_q.num_strips <= pwdata[mpc_pkg::ctrl_num_lsb +: mpc_pkg::strip_w];
				end
				if (is_addr)
					cmd_q.base_addr <= pwdata[mpc_pkg::addr_w-1:0];
			end
			// A status read clears done, even in the cycle it is being set
			if (rd_acc && is_status)
				done_q <= 1'b0;
			else if (busy_fell)
				done_q <= 1'b1;
		end
	end

	// Read mux; done already shows in the cycle busy falls
	always_comb begin
		prdata = '0;
		if (is_ctrl) begin
			prdata[mpc_pkg::ctrl_op_bit] = cmd_q.op;
			prdata[mpc_pkg::ctrl_num_lsb +: mpc_pkg::strip_w] = cmd_q.num_strips;
		end else if (is_addr) begin
			prdata[mpc_pkg::addr_w-1:0] = cmd_q.base_addr;
		end else if (is_status) begin
			prdata[mpc_pkg::st_busy_bit] = busy;
			prdata[mpc_pkg::st_done_bit] = done_q || busy_fell;
		end else if (in_buf) begin
			prdata = buf_rdata;
		end
	end

endmodule

//--- hw/mpc_fsm.sv
`timescale 1ns/1ns

module mpc_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  mpc_pkg::xfer_cmd_t xfer_cmd,
	output logic busy,
	output mpc_pkg::mpc_state_t state,
	input  logic last,
	input  mpc_pkg::strip_t strip_cnt,
	output mpc_pkg::mem_req_t mem_req,
	input  mpc_pkg::mem_rsp_t mem_rsp,
	output logic wr_strobe,
	output logic rd_strobe,
	output logic buf_we,
	input  mpc_pkg::data_t buf_rdata
);

	mpc_pkg::mpc_state_t next_state;
	mpc_pkg::xfer_cmd_t cmd_q;
	mpc_pkg::addr_t req_addr;
	mpc_pkg::addr_t next_addr;
	mpc_pkg::data_t req_wdata;
	logic req_en;
	logic accept;

	assign busy = (state != mpc_pkg::IDLE);

	// Next beat address, base plus the index after the current one
	assign next_addr = cmd_q.base_addr + mpc_pkg::addr_t'(strip_cnt) + mpc_pkg::addr_t'(1);

	assign mem_req = '{en: req_en, cmd: cmd_q.op, addr: req_addr, wdata: req_wdata};

	// Writes accept command and data together, reads only the command here
	assign accept = req_en
		&& ((cmd_q.op == mpc_pkg::OP_WRITE) ? mem_rsp.wdf_rdy : mem_rsp.cmd_rdy);
	assign wr_strobe = (state == mpc_pkg::WRITE_DATA0) && accept;
	assign rd_strobe = (state == mpc_pkg::READ_DATA1) && mem_rsp.rd_valid;
	// Returned read data goes straight into the buffer at strip_cnt
	assign buf_we = rd_strobe;

	// ==================================================
	// State sequencing
	// ==================================================

	always_comb begin
		next_state = state;
		case (state)
			mpc_pkg::IDLE:
				if (start)
					next_state = mpc_pkg::PRESET1;
			mpc_pkg::PRESET1: next_state = mpc_pkg::PRESET2;
			mpc_pkg::PRESET2: next_state = mpc_pkg::PRESET3;
			mpc_pkg::PRESET3:
				next_state = (cmd_q.op == mpc_pkg::OP_WRITE) ? mpc_pkg::WRITE_DATA0
					: mpc_pkg::READ_DATA0;
			// The counter's last flag alone ends the data phase
			mpc_pkg::WRITE_DATA0:
				if (wr_strobe && last)
					next_state = mpc_pkg::DONE;
			mpc_pkg::READ_DATA0:
				if (accept)
					next_state = mpc_pkg::READ_DATA1;
			mpc_pkg::READ_DATA1:
				if (rd_strobe)
					next_state = last ? mpc_pkg::DONE : mpc_pkg::READ_DATA0;
			default: next_state = mpc_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mpc_pkg::IDLE;
			req_en <= 1'b0;
		end else begin
			state <= next_state;
			// The request is live in exactly the two issuing states
			req_en <= (next_state == mpc_pkg::WRITE_DATA0) || (next_state == mpc_pkg::READ_DATA0);
		end
	end

	// Command, address and data registers of the request
	always_ff @(posedge clk) begin
		case (state)
			mpc_pkg::PRESET1: cmd_q <= xfer_cmd;
			mpc_pkg::PRESET2: req_addr <= cmd_q.base_addr;
			// Buffer word 0 was read during PRESET2
			mpc_pkg::PRESET3: req_wdata <= buf_rdata;
			mpc_pkg::WRITE_DATA0:
				if (wr_strobe) begin
					// The buffer already holds the next word on its read port
					req_addr <= next_addr;
					req_wdata <= buf_rdata;
				end
			mpc_pkg::READ_DATA1:
				if (rd_strobe)
					req_addr <= next_addr;
			default: ;
		endcase
	end

	// A pending request must not move until the memory takes it
	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req.en && !accept |=> mem_req.en && $stable(mem_req))
		else $error("memory request changed before acceptance");

endmodule

//--- hw/mpc_pkg.sv
package mpc_pkg;

	// ==================================================
	// Widths and sizes
	// ==================================================

	localparam int data_w = 32;
	localparam int addr_w = 24;
	localparam int strip_w = 6;
	localparam int buf_depth = 64;
	localparam int apb_addr_w = 12;

	typedef logic [data_w-1:0] data_t;
	typedef logic [addr_w-1:0] addr_t;
	typedef logic [strip_w-1:0] strip_t;
	typedef logic [apb_addr_w-1:0] apb_addr_t;

	// ==================================================
	// Register map
	// ==================================================

	localparam apb_addr_t reg_ctrl = 12'h000;
	localparam apb_addr_t reg_addr = 12'h004;
	localparam apb_addr_t reg_status = 12'h008;
	// Buffer words sit at 0x100 to 0x1FC, one word per strip
	localparam apb_addr_t buf_base = 12'h100;
	localparam apb_addr_t buf_last = buf_base + apb_addr_t'(4 * buf_depth - 4);

	// Control register: bit 0 starts a transfer, bit 1 selects the opcode,
	// bits 13:8 hold num_strips
	localparam int ctrl_start_bit = 0;
	localparam int ctrl_op_bit = 1;
	localparam int ctrl_num_lsb = 8;
	// Status register: bit 0 busy, bit 1 sticky done
	localparam int st_busy_bit = 0;
	localparam int st_done_bit = 1;

	typedef enum logic [2:0] {
		IDLE, PRESET1, PRESET2, PRESET3, WRITE_DATA0, READ_DATA0, READ_DATA1, DONE
	} mpc_state_t;

	typedef enum logic [0:0] {OP_READ = 1'b0, OP_WRITE = 1'b1} mpc_op_t;

	typedef struct packed {
		logic en;
		mpc_op_t cmd;
		addr_t addr;
		data_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic cmd_rdy;
		logic wdf_rdy;
		logic rd_valid;
		data_t rd_data;
	} mem_rsp_t;

	typedef struct packed {
		mpc_op_t op;
		strip_t num_strips;
		addr_t base_addr;
	} xfer_cmd_t;

endpackage

//--- hw/mpc_strip_buf.sv
`timescale 1ns/1ns

module mpc_strip_buf (
	input  logic clk,
	// APB side
	input  logic a_we,
	input  mpc_pkg::strip_t a_addr,
	input  mpc_pkg::data_t a_wdata,
	output mpc_pkg::data_t a_rdata,
	// Memory side
	input  logic b_we,
	input  mpc_pkg::strip_t b_addr,
	input  mpc_pkg::data_t b_wdata,
	output mpc_pkg::data_t b_rdata
);

	// ==================================================
	// Storage
	// ==================================================

	// One word per strip
	mpc_pkg::data_t mem [mpc_pkg::buf_depth];

	// Both ports write through one process
	always_ff @(posedge clk) begin
		if (a_we)
			mem[a_addr] <= a_wdata;
		if (b_we)
			mem[b_addr] <= b_wdata;
	end

	// ==================================================
	// Registered reads
	// ==================================================

	// APB reads every cycle, which covers the setup-phase pre-fetch
	always_ff @(posedge clk) begin
		a_rdata <= mem[a_addr];
	end

	// Memory side reads ahead for the write path
	always_ff @(posedge clk) begin
		b_rdata <= mem[b_addr];
	end

	// APB writes only while idle and the memory side only while busy,
	// so the two write enables are never high together
	a_one_writer: assert property (@(posedge clk) !(a_we && b_we))
		else $error("strip buffer written from both ports at once");

endmodule

//--- hw/mpc_strip_cnt.sv
`timescale 1ns/1ns

module mpc_strip_cnt (
	input  logic clk,
	input  logic rst_n,
	input  mpc_pkg::mpc_state_t state,
	input  logic wr_strobe,
	input  logic rd_strobe,
	input  mpc_pkg::strip_t num_strips,
	output mpc_pkg::strip_t strip_cnt,
	output logic last
);

	logic armed;
	logic step;

	// A beat counts on a write accept or on returned read data
	assign step = armed && (((state == mpc_pkg::WRITE_DATA0) && wr_strobe)
		|| ((state == mpc_pkg::READ_DATA1) && rd_strobe));

	// Current beat is the final one
	assign last = armed && (strip_cnt == num_strips);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			strip_cnt <= '0;
			armed <= 1'b0;
		end else if (state == mpc_pkg::IDLE) begin
			strip_cnt <= '0;
			armed <= 1'b0;
		end else begin
			if (state == mpc_pkg::PRESET3)
				armed <= 1'b1;
			// Stop at num_strips and disarm on the final beat
			if (step) begin
				if (strip_cnt != num_strips)
					strip_cnt <= strip_cnt + mpc_pkg::strip_t'(1);
				else
					armed <= 1'b0;
			end
		end
	end

	// The registers hold num_strips fixed for the whole transfer
	a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
		(state != mpc_pkg::IDLE) |-> (strip_cnt <= num_strips))
		else $error("strip count passed num_strips");

endmodule

//--- hw/mpc_top.sv
`timescale 1ns/1ns

module mpc_top (
	input  logic clk,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  mpc_pkg::apb_addr_t paddr,
	input  mpc_pkg::data_t pwdata,
	output mpc_pkg::data_t prdata,
	output logic pready,
	output logic pslverr,
	output mpc_pkg::mem_req_t mem_req,
	input  mpc_pkg::mem_rsp_t mem_rsp
);

	logic start;
	logic busy;
	mpc_pkg::xfer_cmd_t xfer_cmd;
	mpc_pkg::mpc_state_t state;
	logic last;
	mpc_pkg::strip_t strip_cnt;
	logic wr_strobe;
	logic rd_strobe;
	logic a_we;
	mpc_pkg::strip_t a_addr;
	mpc_pkg::data_t a_wdata;
	mpc_pkg::data_t a_rdata;
	logic b_we;
	logic pre_rd;
	mpc_pkg::strip_t b_addr;
	mpc_pkg::data_t b_rdata;

	// ==================================================
	// Memory-side buffer address
	// ==================================================

	// Reads run one word ahead of strip_cnt on the write path, two ahead
	// in a handshake cycle since the counter steps at the same edge
	assign pre_rd = (state == mpc_pkg::PRESET3) || (state == mpc_pkg::WRITE_DATA0);
	assign b_addr = strip_cnt + mpc_pkg::strip_t'(pre_rd) + mpc_pkg::strip_t'(wr_strobe);

	mpc_apb_regs regs_i (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.busy(busy), .start(start), .xfer_cmd(xfer_cmd),
		.buf_we(a_we), .buf_addr(a_addr), .buf_wdata(a_wdata), .buf_rdata(a_rdata)
	);

	mpc_fsm fsm_i (
		.clk(clk), .rst_n(rst_n), .start(start), .xfer_cmd(xfer_cmd),
		.busy(busy), .state(state), .last(last), .strip_cnt(strip_cnt),
		.mem_req(mem_req), .mem_rsp(mem_rsp),
		.wr_strobe(wr_strobe), .rd_strobe(rd_strobe),
		.buf_we(b_we), .buf_rdata(b_rdata)
	);

	// num_strips comes from the registers, which stay frozen while busy
	mpc_strip_cnt cnt_i (
		.clk(clk), .rst_n(rst_n), .state(state),
		.wr_strobe(wr_strobe), .rd_strobe(rd_strobe),
		.num_strips(xfer_cmd.num_strips), .strip_cnt(strip_cnt), .last(last)
	);

	mpc_strip_buf buf_i (
		.clk(clk),
		.a_we(a_we), .a_addr(a_addr), .a_wdata(a_wdata), .a_rdata(a_rdata),
		.b_we(b_we), .b_addr(b_addr), .b_wdata(mem_rsp.rd_data), .b_rdata(b_rdata)
	);

endmodule

//--- test/tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model (
	input  logic clk,
	input  logic rst_n,
	input  mpc_pkg::mem_req_t mem_req,
	output mpc_pkg::mem_rsp_t mem_rsp
);

	localparam int mem_words = 1024;

	// Word storage, indexed by the low ten address bits
	mpc_pkg::data_t mem [mem_words];
	// Accepted write beats and read commands since time zero
	int wr_beats;
	int rd_cmds;

	logic [31:0] lcg_state;
	logic [31:0] r;
	logic cmd_rdy;
	logic wdf_rdy;
	logic rd_valid;
	mpc_pkg::data_t rd_data;
	logic pending;
	int lat;
	mpc_pkg::addr_t rd_addr;

	assign mem_rsp = '{cmd_rdy: cmd_rdy, wdf_rdy: wdf_rdy, rd_valid: rd_valid, rd_data: rd_data};

	// Same LCG constants as the testbench, own state
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	initial begin
		lcg_state = 32'd60094;
		wr_beats = 0;
		rd_cmds = 0;
		cmd_rdy = 1'b0;
		wdf_rdy = 1'b0;
		rd_valid = 1'b0;
		rd_data = '0;
		pending = 1'b0;
		lat = 0;
		rd_addr = '0;
		// Every word starts from a pattern that mixes in its whole address
		for (int i = 0; i < mem_words; i++)
			mem[10'(i)] = (32'(i) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
	end

	// ==================================================
	// Handshakes seen at the edge, new outputs 1 ns later
	// ==================================================

	always @(posedge clk) begin
		if (rst_n && mem_req.en) begin
			// A write beat takes command and data in one step
			if (mem_req.cmd == mpc_pkg::OP_WRITE && wdf_rdy) begin
				mem[mem_req.addr[9:0]] = mem_req.wdata;
				wr_beats++;
			end
			// A read command returns its data 1 to 4 cycles later
			if (mem_req.cmd == mpc_pkg::OP_READ && cmd_rdy) begin
				r = next_rand();
				lat = 1 + int'(r[17:16]);
				rd_addr = mem_req.addr;
				pending = 1'b1;
				rd_cmds++;
			end
		end
		#1;
		r = next_rand();
		// Each ready drops about one cycle in four
		cmd_rdy = rst_n && (r[31:30] != 2'b00);
		wdf_rdy = rst_n && (r[29:28] != 2'b00);
		rd_valid = 1'b0;
		if (pending) begin
			lat--;
			if (lat == 0) begin
				rd_valid = 1'b1;
				rd_data = mem[rd_addr[9:0]];
				pending = 1'b0;
			end
		end
	end

endmodule

//--- test/tb_mpc.sv
`timescale 1ns/1ns

module tb_mpc;

	localparam int n_tests = 6;
	localparam int cycle_ns = 4;
	// Every test gets 64 beats at 12 cycles each, plus room for APB traffic
	localparam int watchdog_ns = n_tests * 64 * 12 * cycle_ns + 20000;
	localparam int max_polls = 400;
	localparam int mem_words = 1024;

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	mpc_pkg::apb_addr_t paddr;
	mpc_pkg::data_t pwdata;
	mpc_pkg::data_t prdata;
	logic pready;
	logic pslverr;
	mpc_pkg::mem_req_t mem_req;
	mpc_pkg::mem_rsp_t mem_rsp;

	// Shadow copies of the external memory and the strip buffer
	mpc_pkg::data_t shadow_mem [mem_words];
	mpc_pkg::data_t shadow_buf [mpc_pkg::buf_depth];
	logic [31:0] rand_state;
	int errors = 0;
	int test_errors = 0;
	int tests_ok = 0;
	int tests_bad = 0;
	string test_name;

	// Expected request sequence of the transfer in flight
	mpc_pkg::mpc_op_t exp_op = mpc_pkg::OP_READ;
	mpc_pkg::addr_t exp_base = '0;
	int exp_beats = 0;
	int seq_origin = 0;
	int acc_count = 0;
	int wr_origin = 0;
	int rd_origin = 0;

	mpc_top dut_i (
		.clk(clk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.mem_req(mem_req), .mem_rsp(mem_rsp)
	);

	tb_mem_model mem_i (.clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_rsp(mem_rsp));

	initial begin
		clk = 1'b0;
		forever #(cycle_ns / 2) clk = ~clk;
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("test failed");
		$finish;
	end

	// ==================================================
	// Reference model and checking
	// ==================================================

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// Expected memory word at a word address
	function automatic mpc_pkg::data_t expect_word(input mpc_pkg::addr_t addr);
		return shadow_mem[addr[9:0]];
	endfunction

	function automatic logic [9:0] word_index(input mpc_pkg::addr_t base, input int i);
		return 10'(int'(base) + i);
	endfunction

	function automatic mpc_pkg::apb_addr_t buf_addr(input int i);
		return mpc_pkg::buf_base + mpc_pkg::apb_addr_t'(4 * i);
	endfunction

	function automatic mpc_pkg::data_t make_ctrl(input mpc_pkg::mpc_op_t op, input int num);
		mpc_pkg::data_t w;
		w = '0;
		w[mpc_pkg::ctrl_start_bit] = 1'b1;
		w[mpc_pkg::ctrl_op_bit] = op;
		w[mpc_pkg::ctrl_num_lsb +: mpc_pkg::strip_w] = mpc_pkg::strip_t'(num);
		return w;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t ns: %s: got %h, expected %h", $time, what, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	// Every accepted request must follow base plus index, in order
	always @(negedge clk) begin : compare_requests
		int idx;
		if (rst_n && mem_req.en
			&& ((mem_req.cmd == mpc_pkg::OP_WRITE && mem_rsp.wdf_rdy)
			|| (mem_req.cmd == mpc_pkg::OP_READ && mem_rsp.cmd_rdy))) begin
			idx = acc_count - seq_origin;
			check_value("request opcode", 32'(mem_req.cmd), 32'(exp_op));
			check_value("beat within transfer", 32'(idx < exp_beats), 32'd1);
			check_value("beat address", 32'(mem_req.addr),
				32'(exp_base + mpc_pkg::addr_t'(idx)));
			if (mem_req.cmd == mpc_pkg::OP_WRITE)
				check_value("beat write data", mem_req.wdata,
					expect_word(exp_base + mpc_pkg::addr_t'(idx)));
			acc_count++;
		end
	end

	// ==================================================
	// APB access
	// ==================================================

	// Setup phase, access phase, then one idle cycle
	task automatic apb_cycle(input logic wr, input mpc_pkg::apb_addr_t addr,
		input mpc_pkg::data_t wdata, output mpc_pkg::data_t rdata, output logic err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		// Sample mid-cycle once the responses have settled
		@(negedge clk);
		rdata = prdata;
		err = pslverr;
		check_value("pready in access phase", 32'(pready), 32'd1);
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic write_word(input mpc_pkg::apb_addr_t addr, input mpc_pkg::data_t data,
		input logic exp_err);
		mpc_pkg::data_t d;
		logic err;
		apb_cycle(1'b1, addr, data, d, err);
		check_value($sformatf("pslverr on write to %h", addr), 32'(err), 32'(exp_err));
	endtask

	task automatic read_word(input mpc_pkg::apb_addr_t addr, input logic exp_err,
		output mpc_pkg::data_t data);
		logic err;
		apb_cycle(1'b0, addr, '0, data, err);
		check_value($sformatf("pslverr on read of %h", addr), 32'(err), 32'(exp_err));
	endtask

	// Random words or zeros into buffer words 0 to num
	task automatic load_buffer(input int num, input logic random);
		mpc_pkg::data_t w;
		for (int i = 0; i <= num; i++) begin
			w = random ? next_rand() : '0;
			write_word(buf_addr(i), w, 1'b0);
			shadow_buf[6'(i)] = w;
		end
	endtask

	// ==================================================
	// Transfers
	// ==================================================

	task automatic start_xfer(input mpc_pkg::mpc_op_t op, input mpc_pkg::addr_t base,
		input int num);
		exp_op = op;
		exp_base = base;
		exp_beats = num + 1;
		seq_origin = acc_count;
		wr_origin = mem_i.wr_beats;
		rd_origin = mem_i.rd_cmds;
		// The command itself moves the shadow data
		for (int i = 0; i <= num; i++) begin
			if (op == mpc_pkg::OP_WRITE)
				shadow_mem[word_index(base, i)] = shadow_buf[6'(i)];
			else
				shadow_buf[6'(i)] = shadow_mem[word_index(base, i)];
		end
		write_word(mpc_pkg::reg_addr, 32'(base), 1'b0);
		write_word(mpc_pkg::reg_ctrl, make_ctrl(op, num), 1'b0);
	endtask

	task automatic check_memory(input mpc_pkg::addr_t base, input int beats);
		for (int i = 0; i < beats; i++)
			check_value($sformatf("memory word %h", base + mpc_pkg::addr_t'(i)),
				mem_i.mem[word_index(base, i)], expect_word(base + mpc_pkg::addr_t'(i)));
	endtask

	// Poll status until busy drops, then check done and its clear-on-read
	task automatic finish_xfer();
		mpc_pkg::data_t st;
		int polls;
		logic busy;
		polls = 0;
		busy = 1'b1;
		while (busy && polls < max_polls) begin
			read_word(mpc_pkg::reg_status, 1'b0, st);
			busy = st[mpc_pkg::st_busy_bit];
			polls++;
		end
		if (busy) begin
			$display("Transfer did not finish: busy still set after %0d status reads", polls);
			errors++;
			test_errors++;
		end else begin
			check_value("done bit at end of transfer", 32'(st[mpc_pkg::st_done_bit]), 32'd1);
		end
		read_word(mpc_pkg::reg_status, 1'b0, st);
		check_value("status after done was read", st, 32'd0);
		check_value("accepted requests", 32'(acc_count - seq_origin), 32'(exp_beats));
		if (exp_op == mpc_pkg::OP_WRITE) begin
			check_value("write beats at memory", 32'(mem_i.wr_beats - wr_origin),
				32'(exp_beats));
			check_memory(exp_base, exp_beats);
		end else begin
			check_value("read commands at memory", 32'(mem_i.rd_cmds - rd_origin),
				32'(exp_beats));
		end
	endtask

	// Buffer words 0 to num against the expected memory region
	task automatic check_region(input mpc_pkg::addr_t base, input int num);
		mpc_pkg::data_t d;
		for (int i = 0; i <= num; i++) begin
			read_word(buf_addr(i), 1'b0, d);
			check_value($sformatf("buffer word %0d", i), d,
				expect_word(base + mpc_pkg::addr_t'(i)));
		end
	endtask

	// Write out, clear the buffer, read back and compare
	task automatic round_trip(input mpc_pkg::addr_t base, input int num);
		load_buffer(num, 1'b1);
		start_xfer(mpc_pkg::OP_WRITE, base, num);
		finish_xfer();
		load_buffer(num, 1'b0);
		start_xfer(mpc_pkg::OP_READ, base, num);
		finish_xfer();
		check_region(base, num);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			tests_ok++;
			$display("%-20s ok", test_name);
		end else begin
			tests_bad++;
			$display("%-20s FAILED, %0d errors", test_name, test_errors);
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin : main
		mpc_pkg::data_t d;
		int num;
		mpc_pkg::addr_t base;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rst_n = 1'b0;
		rand_state = 32'd60094;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// The shadow starts from the model's fill pattern
		for (int i = 0; i < mem_words; i++)
			shadow_mem[10'(i)] = mem_i.mem[10'(i)];

		begin_test("reset_values");
		check_value("mem_req.en after reset", 32'(mem_req.en), 32'd0);
		read_word(mpc_pkg::reg_status, 1'b0, d);
		check_value("status after reset", d, 32'd0);
		read_word(mpc_pkg::reg_ctrl, 1'b0, d);
		check_value("control after reset", d, 32'd0);
		end_test();

		begin_test("write_read_8");
		round_trip(24'h000040, 7);
		end_test();

		begin_test("edge_sizes");
		round_trip(24'h000080, 0);
		round_trip(24'h000100, 63);
		end_test();

		begin_test("random_stalls");
		repeat (3) begin
			num = int'(next_rand() & 32'd31);
			base = 24'h000180 + mpc_pkg::addr_t'(next_rand() & 32'd63);
			round_trip(base, num);
		end
		end_test();

		// Error responses while a 64-beat write runs
		begin_test("busy_errors");
		load_buffer(63, 1'b1);
		start_xfer(mpc_pkg::OP_WRITE, 24'h000200, 63);
		write_word(mpc_pkg::reg_ctrl, make_ctrl(mpc_pkg::OP_READ, 5), 1'b1);
		write_word(buf_addr(2), 32'hDEAD_BEEF, 1'b1);
		read_word(12'h00C, 1'b1, d);
		finish_xfer();
		// The rejected buffer write must have left word 2 alone
		check_region(24'h000200, 63);
		end_test();

		begin_test("adjacent_regions");
		load_buffer(15, 1'b1);
		start_xfer(mpc_pkg::OP_WRITE, 24'h000300, 15);
		finish_xfer();
		load_buffer(15, 1'b1);
		start_xfer(mpc_pkg::OP_WRITE, 24'h000310, 15);
		finish_xfer();
		load_buffer(15, 1'b0);
		start_xfer(mpc_pkg::OP_READ, 24'h000300, 15);
		finish_xfer();
		check_region(24'h000300, 15);
		load_buffer(15, 1'b0);
		start_xfer(mpc_pkg::OP_READ, 24'h000310, 15);
		finish_xfer();
		check_region(24'h000310, 15);
		end_test();

		$display("Summary: %0d ok, %0d with errors, %0d mismatches", tests_ok, tests_bad, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule
